// ==== hw/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser (
    input  logic              clk,
    input  logic              rst_n,
    input  dbg_pkg::ch_t      rx_byte,
    input  logic              rx_valid,
    output logic              cmd_valid,
    output dbg_pkg::dbg_cmd_t cmd
);

    dbg_pkg::ch_t     [dbg_pkg::HIST_LEN-1:0] hist;
    dbg_pkg::nibble_t [dbg_pkg::HIST_LEN-1:0] nib;
    logic             [dbg_pkg::HIST_LEN-1:0] hex_ok;
    logic                                     check;

    function automatic logic is_hex(input dbg_pkg::ch_t c);
        return (c >= "0" && c <= "9") || (c >= "A" && c <= "F") || (c >= "a" && c <= "f");
    endfunction

    // only meaningful when is_hex holds
    function automatic dbg_pkg::nibble_t hex_val(input dbg_pkg::ch_t c);
        dbg_pkg::ch_t v;
        if (c <= 8'h39) begin
            v = c - 8'h30;
        end else if (c <= 8'h46) begin
            v = c - 8'h37;
        end else begin
            v = c - 8'h57;
        end
        return v[3:0];
    endfunction

    // hist[0] holds the newest character
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist  <= '0;
            check <= 1'b0;
        end else begin
            check <= rx_valid;
            if (rx_valid) begin
                hist <= {hist[dbg_pkg::HIST_LEN-2:0], rx_byte};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < dbg_pkg::HIST_LEN; i++) begin
            hex_ok[i] = is_hex(hist[i]);
            nib[i]    = hex_val(hist[i]);
        end
    end

    // shortest pattern first, so the latest command wins
    always_comb begin
        cmd = '0;
        if (hist[0] == dbg_pkg::DOT_CH) begin
            if (hist[1] == dbg_pkg::QUEST_CH) begin
                cmd.kind = dbg_pkg::CMD_IDENT;
            end else if (hist[dbg_pkg::ADDR_DIGITS+1] == dbg_pkg::COLON_CH &&
                         &hex_ok[dbg_pkg::ADDR_DIGITS:1]) begin
                cmd.kind = dbg_pkg::CMD_READ;
                cmd.addr = nib[dbg_pkg::ADDR_DIGITS:1];
            end else if (&hex_ok[dbg_pkg::HIST_LEN-2:1] &&
                         (hist[dbg_pkg::HIST_LEN-1] == dbg_pkg::EQ_CH ||
                          hist[dbg_pkg::HIST_LEN-1] == dbg_pkg::GT_CH)) begin
                cmd.kind = (hist[dbg_pkg::HIST_LEN-1] == dbg_pkg::EQ_CH) ?
                           dbg_pkg::CMD_WRITE_REG : dbg_pkg::CMD_WRITE_RAM;
                cmd.addr = nib[dbg_pkg::HIST_LEN-2 -: dbg_pkg::ADDR_DIGITS];
                cmd.data = nib[dbg_pkg::DATA_DIGITS:1];
            end
        end
    end

    assign cmd_valid = check && (cmd.kind != dbg_pkg::CMD_NONE);

    a_cmd_single: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_valid |=> !cmd_valid);

endmodule

// ==== hw/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                reg_write,
    input  regs_pkg::reg_idx_t  reg_idx,
    input  dbg_pkg::word_t      reg_wdata,
    output dbg_pkg::word_t      reg_rdata,
    output regs_pkg::regs_out_t regs_out
);

    regs_pkg::baud_div_t baud;
    regs_pkg::enables_t  enables;
    dbg_pkg::word_t      scratch;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud    <= regs_pkg::BAUD_RESET;
            enables <= regs_pkg::ENABLES_RESET;
            scratch <= regs_pkg::SCRATCH_RESET;
        end else if (reg_write) begin
            case (reg_idx)
                regs_pkg::REG_BAUD:    baud    <= reg_wdata[15:0];
                regs_pkg::REG_ENABLES: enables <= reg_wdata[15:0];
                regs_pkg::REG_SCRATCH: scratch <= reg_wdata;
                // identity word is read only
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_idx)
            regs_pkg::REG_ID:      reg_rdata = regs_pkg::ID_VALUE;
            regs_pkg::REG_BAUD:    reg_rdata = {16'h0000, baud};
            regs_pkg::REG_ENABLES: reg_rdata = {16'h0000, enables};
            default:               reg_rdata = scratch;
        endcase
    end

    assign regs_out = '{baud_div: baud, enables: enables};

endmodule

// ==== hw/dbg_engine.sv ====
`timescale 1ns/1ps

module dbg_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  dbg_pkg::dbg_cmd_t   cmd,
    output logic                reg_write,
    output regs_pkg::reg_idx_t  reg_idx,
    output dbg_pkg::word_t      reg_wdata,
    input  dbg_pkg::word_t      reg_rdata,
    input  dbg_pkg::word_t      enables,
    output dbg_pkg::ram_addr_t  ram_addr,
    output dbg_pkg::word_t      ram_wdata,
    output logic                ram_read,
    output logic                ram_write,
    input  dbg_pkg::word_t      ram_rdata,
    output logic                resp_load,
    output dbg_pkg::resp_line_t resp_line,
    input  logic                resp_busy
);

    dbg_pkg::eng_state_e state;
    dbg_pkg::cmd_e       op_kind;
    dbg_pkg::addr_t      op_addr;
    dbg_pkg::word_t      rdata;
    dbg_pkg::resp_line_t line_next;
    logic                start;

    function automatic dbg_pkg::ch_t hex_ch(input dbg_pkg::nibble_t n);
        return (n < 4'd10) ? 8'h30 + n : 8'h37 + n;
    endfunction

    // commands arriving while busy are dropped
    assign start = cmd_valid && (state == dbg_pkg::ENG_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= dbg_pkg::ENG_IDLE;
            reg_write <= 1'b0;
            ram_read  <= 1'b0;
            ram_write <= 1'b0;
            resp_load <= 1'b0;
        end else begin
            reg_write <= 1'b0;
            ram_read  <= 1'b0;
            ram_write <= 1'b0;
            resp_load <= 1'b0;
            case (state)
                dbg_pkg::ENG_IDLE: begin
                    if (start) begin
                        case (cmd.kind)
                            dbg_pkg::CMD_WRITE_REG: reg_write <= 1'b1;
                            dbg_pkg::CMD_WRITE_RAM: ram_write <= 1'b1;
                            dbg_pkg::CMD_IDENT:     state <= dbg_pkg::ENG_FORMAT;
                            dbg_pkg::CMD_READ: begin
                                ram_read <= cmd.addr[15];
                                state    <= cmd.addr[15] ? dbg_pkg::ENG_RAM_WAIT :
                                                           dbg_pkg::ENG_FORMAT;
                            end
                            default: ;
                        endcase
                    end
                end
                dbg_pkg::ENG_RAM_WAIT: state <= dbg_pkg::ENG_FORMAT;
                dbg_pkg::ENG_FORMAT: begin
                    resp_load <= 1'b1;
                    state     <= dbg_pkg::ENG_WAIT_TX;
                end
                // resp_busy only rises the cycle after resp_load
                default: begin
                    if (!resp_busy && !resp_load) begin
                        state <= dbg_pkg::ENG_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_kind   <= cmd.kind;
            op_addr   <= cmd.addr;
            reg_idx   <= cmd.addr[1:0];
            reg_wdata <= cmd.data;
            ram_addr  <= cmd.addr[13:0];
            ram_wdata <= cmd.data;
        end
        if (state == dbg_pkg::ENG_FORMAT) begin
            resp_line <= line_next;
        end
    end

    assign rdata = op_addr[15] ? ram_rdata : reg_rdata;

    always_comb begin
        line_next = '0;
        if (op_kind == dbg_pkg::CMD_IDENT) begin
            for (int i = 0; i < 4; i++) begin
                line_next.chars[i]   = dbg_pkg::IDENT_TAG[31-8*i -: 8];
                line_next.chars[4+i] = hex_ch(enables[15-4*i -: 4]);
            end
            line_next.len = 4'd8;
        end else begin
            line_next.chars[0] = op_addr[15] ? dbg_pkg::PLUS_CH : dbg_pkg::COLON_CH;
            for (int i = 0; i < dbg_pkg::ADDR_DIGITS; i++) begin
                line_next.chars[1+i] = hex_ch(op_addr[15-4*i -: 4]);
            end
            for (int i = 0; i < dbg_pkg::DATA_DIGITS; i++) begin
                line_next.chars[5+i] = hex_ch(rdata[31-4*i -: 4]);
            end
            line_next.chars[13] = dbg_pkg::DOT_CH;
            line_next.len       = 4'd14;
        end
    end

    // the sender must take every loaded line
    a_resp_taken: assert property (
        @(posedge clk) disable iff (!rst_n) resp_load |=> resp_busy);

endmodule

// ==== hw/dbg_pkg.sv ====
package dbg_pkg;

    typedef logic [7:0]  ch_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [15:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [13:0] ram_addr_t;

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_IDENT,
        CMD_READ,
        CMD_WRITE_REG,
        CMD_WRITE_RAM
    } cmd_e;

    typedef struct packed {
        cmd_e  kind;
        addr_t addr;
        word_t data;
    } dbg_cmd_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_RAM_WAIT,
        ENG_FORMAT,
        ENG_WAIT_TX
    } eng_state_e;

    localparam ch_t DOT_CH   = 8'h2e;
    localparam ch_t COLON_CH = 8'h3a;
    localparam ch_t EQ_CH    = 8'h3d;
    localparam ch_t GT_CH    = 8'h3e;
    localparam ch_t QUEST_CH = 8'h3f;
    localparam ch_t PLUS_CH  = 8'h2b;
    localparam ch_t LF_CH    = 8'h0a;

    // hex digits per field on the line
    localparam int ADDR_DIGITS = 4;
    localparam int DATA_DIGITS = 8;

    localparam int HIST_LEN = 14;
    localparam int RESP_LEN = 14;

    // banner prefix, first character in the top byte
    localparam logic [31:0] IDENT_TAG = "DB10";

    typedef struct packed {
        ch_t [RESP_LEN-1:0] chars;
        logic [3:0]         len;
    } resp_line_t;

endpackage

// ==== hw/dbg_uart.sv ====
`timescale 1ns/1ps

module dbg_uart (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rxd,
    output logic               txd,
    output dbg_pkg::ram_addr_t ram_addr,
    output dbg_pkg::word_t     ram_wdata,
    output logic               ram_read,
    output logic               ram_write,
    input  dbg_pkg::word_t     ram_rdata
);

    dbg_pkg::ch_t        rx_byte;
    logic                rx_valid;
    dbg_pkg::ch_t        tx_byte;
    logic                tx_write;
    logic                tx_empty;
    logic                cmd_valid;
    dbg_pkg::dbg_cmd_t   cmd;
    logic                reg_write;
    regs_pkg::reg_idx_t  reg_idx;
    dbg_pkg::word_t      reg_wdata;
    dbg_pkg::word_t      reg_rdata;
    regs_pkg::regs_out_t regs_out;
    logic                resp_load;
    dbg_pkg::resp_line_t resp_line;
    logic                resp_busy;

    uart_core u_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .txd      (txd),
        .baud_div (regs_out.baud_div),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .tx_byte  (tx_byte),
        .tx_write (tx_write),
        .tx_empty (tx_empty)
    );

    cmd_parser u_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    dbg_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .reg_write (reg_write),
        .reg_idx   (reg_idx),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .enables   ({16'h0000, regs_out.enables}),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_read  (ram_read),
        .ram_write (ram_write),
        .ram_rdata (ram_rdata),
        .resp_load (resp_load),
        .resp_line (resp_line),
        .resp_busy (resp_busy)
    );

    resp_tx u_resp (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .resp_load (resp_load),
        .resp_line (resp_line),
        .resp_busy (resp_busy),
        .tx_byte   (tx_byte),
        .tx_write  (tx_write),
        .tx_empty  (tx_empty)
    );

    ctrl_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_write (reg_write),
        .reg_idx   (reg_idx),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .regs_out  (regs_out)
    );

endmodule

// ==== hw/regs_pkg.sv ====
package regs_pkg;

    typedef logic [1:0]  reg_idx_t;
    typedef logic [15:0] baud_div_t;
    typedef logic [15:0] enables_t;

    localparam reg_idx_t REG_ID      = 2'd0;
    localparam reg_idx_t REG_BAUD    = 2'd1;
    localparam reg_idx_t REG_ENABLES = 2'd2;
    localparam reg_idx_t REG_SCRATCH = 2'd3;

    localparam logic [31:0] ID_VALUE      = 32'hDB10_0100;
    localparam baud_div_t   BAUD_RESET    = 16'd16;
    localparam enables_t    ENABLES_RESET = 16'h0000;
    localparam logic [31:0] SCRATCH_RESET = 32'h0000_0000;

    typedef struct packed {
        baud_div_t baud_div;
        enables_t  enables;
    } regs_out_t;

endpackage

// ==== hw/resp_tx.sv ====
`timescale 1ns/1ps

module resp_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  dbg_pkg::ch_t        rx_byte,
    input  logic                rx_valid,
    input  logic                resp_load,
    input  dbg_pkg::resp_line_t resp_line,
    output logic                resp_busy,
    output dbg_pkg::ch_t        tx_byte,
    output logic                tx_write,
    input  logic                tx_empty
);

    dbg_pkg::resp_line_t line;
    logic [3:0]          ptr;
    logic                last;
    logic                echo_pend;
    dbg_pkg::ch_t        echo_byte;

    // pointer past the text selects the closing LF
    assign last     = (ptr == line.len);
    assign tx_write = tx_empty && (resp_busy || echo_pend);
    assign tx_byte  = !resp_busy ? echo_byte :
                      last       ? dbg_pkg::LF_CH : line.chars[ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_busy <= 1'b0;
            ptr       <= '0;
            echo_pend <= 1'b0;
        end else begin
            if (resp_load) begin
                resp_busy <= 1'b1;
                ptr       <= '0;
            end else if (resp_busy && tx_write) begin
                if (last) begin
                    resp_busy <= 1'b0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
            if (!resp_busy && tx_write) begin
                echo_pend <= 1'b0;
            end
            if (!resp_busy && rx_valid) begin
                echo_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_load) begin
            line <= resp_line;
        end
        if (!resp_busy && rx_valid) begin
            echo_byte <= rx_byte;
        end
    end

    a_load_idle: assert property (
        @(posedge clk) disable iff (!rst_n) resp_load |-> !resp_busy);

endmodule

// ==== hw/uart_core.sv ====
`timescale 1ns/1ps

module uart_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rxd,
    output logic                txd,
    input  regs_pkg::baud_div_t baud_div,
    output dbg_pkg::ch_t        rx_byte,
    output logic                rx_valid,
    input  dbg_pkg::ch_t        tx_byte,
    input  logic                tx_write,
    output logic                tx_empty
);

    logic                rx_meta;
    logic                rx_s;
    logic                rx_busy;
    regs_pkg::baud_div_t rx_cnt;
    logic [3:0]          rx_bit;
    logic                rx_tick;
    dbg_pkg::ch_t        rx_shift;

    logic                tx_busy;
    regs_pkg::baud_div_t tx_cnt;
    logic [3:0]          tx_left;
    logic [9:0]          tx_shift;

    assign rx_tick = rx_busy && (rx_cnt == '0);
    assign rx_byte = rx_shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_s     <= 1'b1;
            rx_busy  <= 1'b0;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rxd;
            rx_s     <= rx_meta;
            rx_valid <= 1'b0;
            if (!rx_busy) begin
                // first sample lands in the middle of the start bit
                if (!rx_s) begin
                    rx_busy <= 1'b1;
                    rx_cnt  <= baud_div >> 1;
                    rx_bit  <= '0;
                end
            end else if (!rx_tick) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                rx_cnt <= baud_div - 1'b1;
                rx_bit <= rx_bit + 1'b1;
                if (rx_bit == 4'd0 && rx_s) begin
                    rx_busy <= 1'b0;
                end else if (rx_bit == 4'd9) begin
                    rx_busy  <= 1'b0;
                    rx_valid <= rx_s;  // bad stop bit drops the frame
                end
            end
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (rx_tick && rx_bit != 4'd0 && rx_bit != 4'd9) begin
            rx_shift <= {rx_s, rx_shift[7:1]};
        end
    end

    assign txd      = tx_shift[0];
    assign tx_empty = !tx_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            tx_cnt   <= '0;
            tx_left  <= '0;
            tx_shift <= '1;
        end else if (!tx_busy) begin
            if (tx_write) begin
                tx_busy  <= 1'b1;
                tx_cnt   <= baud_div - 1'b1;
                tx_left  <= 4'd9;
                tx_shift <= {1'b1, tx_byte, 1'b0};
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 1'b1;
        end else if (tx_left == '0) begin
            tx_busy <= 1'b0;
        end else begin
            tx_cnt   <= baud_div - 1'b1;
            tx_left  <= tx_left - 1'b1;
            tx_shift <= {1'b1, tx_shift[9:1]};
        end
    end

    a_tx_write_empty: assert property (
        @(posedge clk) disable iff (!rst_n) tx_write |-> tx_empty);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dbg_uart testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_dbg_uart
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module "$top" -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
    echo "RESULT: FAIL"
    exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "Simulation passed" "$log"; then
    echo "RESULT: FAIL (simulation status $run_status)"
    exit 1
fi
echo "RESULT: PASS"
exit 0

// ==== sim.f ====
hw/dbg_pkg.sv
hw/regs_pkg.sv
hw/uart_core.sv
hw/cmd_parser.sv
hw/dbg_engine.sv
hw/resp_tx.sv
hw/ctrl_regs.sv
hw/dbg_uart.sv
sim/tb_dbg_uart.sv

// ==== sim/tb_dbg_uart.sv ====
`timescale 1ns/1ps

module tb_dbg_uart;

    localparam int CLK_PERIOD  = 40;
    localparam int BIT_CYCLES  = int'(regs_pkg::BAUD_RESET);
    localparam int CHAR_CYCLES = 10 * BIT_CYCLES;
    // characters sent, response characters and quiet windows over all tests
    localparam int TOTAL_CHARS     = 85 + 63 + 18;
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_CHARS * CHAR_CYCLES;
    localparam int QUIET_CYCLES    = 3 * CHAR_CYCLES;

    typedef struct packed {
        logic               allowed;
        dbg_pkg::ram_addr_t addr;
        dbg_pkg::word_t     wdata;
    } ram_expect_t;

    logic               clk;
    logic               rst_n;
    logic               rxd;
    logic               txd;
    dbg_pkg::ram_addr_t ram_addr;
    dbg_pkg::word_t     ram_wdata;
    logic               ram_read;
    logic               ram_write;
    dbg_pkg::word_t     ram_rdata;

    dbg_pkg::ch_t       line_q[$];
    dbg_pkg::word_t     mem [0:16383];
    int                 ram_reads;
    int                 ram_writes;
    ram_expect_t        ram_exp;
    dbg_pkg::word_t     lcg_state;

    dbg_uart UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .txd       (txd),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_read  (ram_read),
        .ram_write (ram_write),
        .ram_rdata (ram_rdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input string got, input string exp);
        abort_run($sformatf("ERR %0t %s got %s expected %s", $time, sig, got, exp));
    endtask

    function automatic dbg_pkg::word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic string hex_text(input dbg_pkg::word_t v, input int digits, input bit upper);
        string tbl;
        string s;
        tbl = upper ? "0123456789ABCDEF" : "0123456789abcdef";
        s = "";
        for (int i = digits - 1; i >= 0; i--) begin
            s = $sformatf("%s%c", s, tbl[int'(v[4*i +: 4])]);
        end
        return s;
    endfunction

    // 8N1 with two stop bits so the echo keeps pace with the host
    task automatic send_char(input dbg_pkg::ch_t c);
        logic [10:0] frame;
        frame = {2'b11, c, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            #2;
            rxd = frame[i];
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_char(s[i]);
        end
    endtask

    task automatic next_char(output dbg_pkg::ch_t c);
        int waited;
        waited = 0;
        while (line_q.size() == 0) begin
            if (waited >= 4 * CHAR_CYCLES) begin
                abort_run("no character arrived on txd in time");
            end
            @(posedge clk);
            waited++;
        end
        c = line_q.pop_front();
    endtask

    task automatic collect_line(output string text);
        dbg_pkg::ch_t c;
        text = "";
        next_char(c);
        while (c != dbg_pkg::LF_CH) begin
            if (text.len() > 40) begin
                abort_run("response on txd never ended with a line feed");
            end
            text = $sformatf("%s%c", text, c);
            next_char(c);
        end
    endtask

    // echo of the command, then the response text up to LF
    task automatic expect_line(input string cmd, input string resp);
        string got;
        send_text(cmd);
        collect_line(got);
        assert (got == {cmd, resp}) else report_mismatch("txd", got, {cmd, resp});
    endtask

    task automatic expect_echo(input string cmd);
        string        got;
        dbg_pkg::ch_t c;
        send_text(cmd);
        got = "";
        for (int i = 0; i < cmd.len(); i++) begin
            next_char(c);
            got = $sformatf("%s%c", got, c);
        end
        assert (got == cmd) else report_mismatch("txd", got, cmd);
        repeat (QUIET_CYCLES) @(posedge clk);
        assert (line_q.size() == 0)
            else abort_run($sformatf("unexpected response on txd after %s", cmd));
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // word RAM, read data follows ram_read by one cycle
    initial begin
        dbg_pkg::ram_addr_t rd_addr;
        ram_rdata  = '0;
        ram_reads  = 0;
        ram_writes = 0;
        for (int i = 0; i < 16384; i++) begin
            mem[i] = 32'hC0DE_0000 ^ i;
        end
        forever begin
            @(negedge clk);
            if (ram_write) begin
                mem[ram_addr] = ram_wdata;
                ram_writes++;
            end
            if (ram_read) begin
                rd_addr = ram_addr;
                ram_reads++;
                @(posedge clk);
                #2;
                ram_rdata = mem[rd_addr];
            end
        end
    end

    // txd decoder, samples mid bit on the falling edge
    initial begin
        dbg_pkg::ch_t c;
        forever begin
            @(negedge clk);
            if (txd === 1'b0) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    c[i] = txd;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                if (txd !== 1'b1) begin
                    abort_run("framing error on txd, the stop bit was low");
                end
                line_q.push_back(c);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    a_ram_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !ram_exp.allowed |-> !(ram_read || ram_write))
        else abort_run("RAM strobe seen while no RAM access was expected");

    a_ram_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (ram_read || ram_write) |-> ram_addr == ram_exp.addr)
        else report_mismatch("ram_addr", $sformatf("%04h", $sampled(ram_addr)),
                             $sformatf("%04h", $sampled(ram_exp.addr)));

    a_ram_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        ram_write |-> ram_wdata == ram_exp.wdata)
        else report_mismatch("ram_wdata", $sformatf("%08h", $sampled(ram_wdata)),
                             $sformatf("%08h", $sampled(ram_exp.wdata)));

    initial begin
        dbg_pkg::word_t w;
        dbg_pkg::word_t en;
        int             count_before;
        rst_n     = 1'b0;
        rxd       = 1'b1;
        ram_exp   = '0;
        lcg_state = 32'd58;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (20) begin
            @(negedge clk);
            assert (txd === 1'b1) else report_mismatch("txd", $sformatf("%b", txd), "1");
            assert (ram_read === 1'b0)
                else report_mismatch("ram_read", $sformatf("%b", ram_read), "0");
            assert (ram_write === 1'b0)
                else report_mismatch("ram_write", $sformatf("%b", ram_write), "0");
        end
        expect_line("?.", "DB100000");

        // scratch round trip, data sent in lower case
        w = next_random();
        expect_echo({"=0003", hex_text(w, 8, 1'b0), "."});
        expect_line(":0003.", {":0003", hex_text(w, 8, 1'b1), "."});

        expect_echo({"=0000", hex_text(next_random(), 8, 1'b1), "."});
        expect_line(":0000.", {":0000", hex_text(regs_pkg::ID_VALUE, 8, 1'b1), "."});
        en = next_random();
        expect_echo({"=0002", hex_text(en, 8, 1'b1), "."});
        expect_line("?.", {"DB10", hex_text({16'h0000, en[15:0]}, 4, 1'b1)});

        w = next_random();
        ram_exp = '{allowed: 1'b1, addr: 14'h0010, wdata: w};
        count_before = ram_writes;
        expect_echo({">8010", hex_text(w, 8, 1'b1), "."});
        assert (ram_writes == count_before + 1)
            else report_mismatch("ram_write", $sformatf("%0d pulses", ram_writes - count_before),
                                 "1 pulse");
        count_before = ram_reads;
        expect_line(":8010.", {"+8010", hex_text(w, 8, 1'b1), "."});
        assert (ram_reads == count_before + 1)
            else report_mismatch("ram_read", $sformatf("%0d pulses", ram_reads - count_before),
                                 "1 pulse");
        ram_exp.allowed = 1'b0;

        // bad hex digit, then a lone dot
        expect_echo(":00G1.");
        expect_echo(".");

        $display("Simulation passed");
        $finish;
    end

endmodule
